/* tb.f */
+incdir+tests
source/timer_bus_pkg.sv
source/timer_regs_pkg.sv
source/timer_req_ingress.sv
source/timer_req_fifo.sv
source/machine_timer.sv
source/timer_subsystem.sv
tests/timer_tb.sv

/* tests/timer_tb_checks.svh */
`ifndef TIMER_TB_CHECKS_SVH
`define TIMER_TB_CHECKS_SVH

// every task here is entered and left just after a falling clock edge

task automatic send_request(input logic wr, input logic [7:0] addr, input logic [31:0] data);
    int waited;
    waited = 0;
    while (host_credits == 0) begin
        if (waited == CREDIT_TIMEOUT) begin
            stop_on_failure("no credit came back so the next request cannot be sent");
        end
        @(negedge CLK);
        waited++;
    end
    req.write    = wr;
    req.addr     = addr;
    req.data     = data;
    req_valid    = 1'b1;
    host_credits--;         // the beat spends its credit right away
    @(negedge CLK);
    req_valid    = 1'b0;
endtask

task automatic wait_response(output timer_bus_pkg::timer_rsp_t got);
    int waited;
    waited = 0;
    while (rsp_queue.size() == 0) begin
        if (waited == RSP_TIMEOUT) begin
            stop_on_failure("a request got no response in time");
        end
        @(negedge CLK);
        waited++;
    end
    got            = rsp_queue.pop_front();
    last_rsp_cycle = stamp_queue.pop_front();
endtask

function automatic timer_bus_pkg::timer_rsp_t rsp_of(input timer_bus_pkg::timer_status_e status,
                                                     input logic [31:0] data);
    timer_bus_pkg::timer_rsp_t r;
    r.status = status;
    r.data   = data;
    return r;
endfunction

task automatic read_reg(input logic [7:0] addr, output timer_bus_pkg::timer_rsp_t got);
    send_request(1'b0, addr, 32'h0);
    wait_response(got);
endtask

task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                         output timer_bus_pkg::timer_rsp_t got);
    send_request(1'b1, addr, data);
    wait_response(got);
endtask

// a plain register write, which answers OK with zero data
task automatic write_ok(input logic [7:0] addr, input logic [31:0] data);
    timer_bus_pkg::timer_rsp_t got;
    write_reg(addr, data, got);
    compare_rsp("rsp write", got, rsp_of(timer_bus_pkg::OK, 32'h0));
endtask

task automatic read_pair(input logic [7:0] addr_l, input logic [7:0] addr_h,
                         output logic [63:0] value);
    timer_bus_pkg::timer_rsp_t low;
    timer_bus_pkg::timer_rsp_t high;
    read_reg(addr_l, low);
    expect_status("rsp.status", low.status, timer_bus_pkg::OK);
    read_reg(addr_h, high);
    expect_status("rsp.status", high.status, timer_bus_pkg::OK);
    value = {high.data, low.data};
endtask

task automatic compare_rsp(input string name, input timer_bus_pkg::timer_rsp_t got,
                           input timer_bus_pkg::timer_rsp_t exp);
    if (got !== exp) begin
        stop_on_failure($sformatf("[ERROR] %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
endtask

task automatic expect_status(input string name, input timer_bus_pkg::timer_status_e got,
                             input timer_bus_pkg::timer_status_e exp);
    if (got !== exp) begin
        stop_on_failure($sformatf("[ERROR] %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
endtask

// a range check, lo equal to hi asks for an exact value
task automatic verify_count(input string name, input logic [63:0] got,
                            input logic [63:0] lo, input logic [63:0] hi);
    if ($isunknown(got) || got < lo || got > hi) begin
        stop_on_failure($sformatf("[ERROR] %s: got 0x%0h expected 0x%0h to 0x%0h",
                                  name, got, lo, hi));
    end
endtask

task automatic confirm_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        stop_on_failure($sformatf("[ERROR] %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
endtask

`endif

/* tests/timer_tb.sv */
`timescale 1ns/1ps

module timer_tb;

    localparam int CLK_PERIOD     = 8;
    localparam int RESET_CYCLES   = 5;
    localparam int RSP_TIMEOUT    = 50;     // cycles one response may take
    localparam int CREDIT_TIMEOUT = 50;
    localparam int PULSE_TIMEOUT  = 300;
    localparam int LAT_MARGIN     = 2;      // counts the request latency can cost in the count test
    // cycle budget of each test in run order
    localparam int TEST_BUDGET    = 80 + 80 + 520 + 450 + 100;
    localparam int WATCHDOG_NS    = (RESET_CYCLES + TEST_BUDGET + 200) * CLK_PERIOD;

    logic                      CLK;
    logic                      RST_N;
    logic                      req_valid;
    timer_bus_pkg::timer_req_t req;
    logic                      rsp_valid;
    timer_bus_pkg::timer_rsp_t rsp;
    logic                      credit_return;
    logic                      timer_int;
    logic                      timer_pulse;

    timer_bus_pkg::timer_rsp_t rsp_queue [$];
    int                        stamp_queue [$];
    int                        cycle_count;
    int                        last_rsp_cycle;
    int                        host_credits;
    int                        credit_pulses;

    timer_subsystem timer_subsystem_i (
        .CLK           (CLK),
        .RST_N         (RST_N),
        .req_valid     (req_valid),
        .req           (req),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .credit_return (credit_return),
        .timer_int     (timer_int),
        .timer_pulse   (timer_pulse)
    );

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    // the host side of the response channel sees the values held through the previous cycle
    always @(posedge CLK) begin
        cycle_count++;
        if (RST_N && rsp_valid) begin
            rsp_queue.push_back(rsp);
            stamp_queue.push_back(cycle_count);
        end
        if (RST_N && credit_return) begin
            host_credits++;
            credit_pulses++;
        end
    end

    task automatic stop_on_failure(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "run stopped at the first failure");
    endtask

`include "timer_tb_checks.svh"

    task automatic reset_values();
        timer_bus_pkg::timer_rsp_t got;
        read_reg(timer_regs_pkg::ADDR_CTRL, got);
        compare_rsp("rsp ctrl", got, rsp_of(timer_bus_pkg::OK, 32'h0));
        read_reg(timer_regs_pkg::ADDR_MTIME_L, got);
        compare_rsp("rsp mtime_l", got, rsp_of(timer_bus_pkg::OK, 32'h0));
        read_reg(timer_regs_pkg::ADDR_MTIME_H, got);
        compare_rsp("rsp mtime_h", got, rsp_of(timer_bus_pkg::OK, 32'h0));
        read_reg(timer_regs_pkg::ADDR_MTIMECMP_L, got);
        compare_rsp("rsp mtimecmp_l", got, rsp_of(timer_bus_pkg::OK, 32'hFFFF_FFFF));
        read_reg(timer_regs_pkg::ADDR_MTIMECMP_H, got);
        compare_rsp("rsp mtimecmp_h", got, rsp_of(timer_bus_pkg::OK, 32'hFFFF_FFFF));
        confirm_level("timer_int", timer_int, 1'b0);
    endtask

    task automatic disabled_and_read_only();
        timer_bus_pkg::timer_rsp_t got;
        read_reg(timer_regs_pkg::ADDR_MTIME_L, got);
        compare_rsp("rsp mtime_l", got, rsp_of(timer_bus_pkg::OK, 32'h0));
        repeat (10) @(negedge CLK);
        // nothing moves while enable is clear
        read_reg(timer_regs_pkg::ADDR_MTIME_L, got);
        compare_rsp("rsp mtime_l", got, rsp_of(timer_bus_pkg::OK, 32'h0));
        write_reg(timer_regs_pkg::ADDR_MTIME_L, $urandom(), got);
        expect_status("rsp.status", got.status, timer_bus_pkg::READ_ONLY);
        compare_rsp("rsp mtime_l write", got, rsp_of(timer_bus_pkg::READ_ONLY, 32'h0));
        read_reg(timer_regs_pkg::ADDR_MTIME_L, got);
        compare_rsp("rsp mtime_l", got, rsp_of(timer_bus_pkg::OK, 32'h0));
        write_reg(8'h20, $urandom(), got);
        compare_rsp("rsp unmapped", got, rsp_of(timer_bus_pkg::BAD_ADDR, 32'h0));
    endtask

    task automatic prescaled_counting();
        timer_regs_pkg::timer_ctrl_word_u ctrl;
        logic [63:0]                      count;
        int                               start_cycle;
        int                               elapsed;
        ctrl.raw           = '0;
        ctrl.ctrl.prescale = 8'd3;
        ctrl.ctrl.enable   = 1'b1;
        write_ok(timer_regs_pkg::ADDR_CTRL, ctrl.raw);
        start_cycle = last_rsp_cycle;
        repeat (400) @(negedge CLK);
        write_ok(timer_regs_pkg::ADDR_CTRL, 32'h0);
        elapsed = last_rsp_cycle - start_cycle;
        read_pair(timer_regs_pkg::ADDR_MTIME_L, timer_regs_pkg::ADDR_MTIME_H, count);
        verify_count("mtime", count, 64'(100 - LAT_MARGIN), 64'd101);
        // one step every four cycles of the measured enabled window
        verify_count("mtime", count, 64'(elapsed / 4 - 1), 64'(elapsed / 4 + 1));
    endtask

    task automatic compare_interrupt();
        logic [63:0] now;
        logic [63:0] cmp;
        logic [63:0] count;
        int          waited;
        read_pair(timer_regs_pkg::ADDR_MTIME_L, timer_regs_pkg::ADDR_MTIME_H, now);
        cmp = now + 64'd50 + 64'($urandom_range(150));
        write_ok(timer_regs_pkg::ADDR_MTIMECMP_L, cmp[31:0]);
        write_ok(timer_regs_pkg::ADDR_MTIMECMP_H, cmp[63:32]);
        write_ok(timer_regs_pkg::ADDR_CTRL, 32'h1);    // enable with prescale 0
        waited = 0;
        while (!timer_pulse) begin
            confirm_level("timer_int", timer_int, 1'b0);
            if (waited == PULSE_TIMEOUT) begin
                stop_on_failure("timer_pulse never came after the counter was enabled");
            end
            @(negedge CLK);
            waited++;
        end
        confirm_level("timer_int", timer_int, 1'b1);
        @(negedge CLK);
        confirm_level("timer_pulse", timer_pulse, 1'b0);
        repeat (10) begin
            confirm_level("timer_int", timer_int, 1'b1);
            @(negedge CLK);
        end
        write_ok(timer_regs_pkg::ADDR_CTRL, 32'h0);
        read_pair(timer_regs_pkg::ADDR_MTIME_L, timer_regs_pkg::ADDR_MTIME_H, count);
        verify_count("mtime", count, cmp, '1);
        write_ok(timer_regs_pkg::ADDR_MTIMECMP_L, 32'hFFFF_FFFF);
        write_ok(timer_regs_pkg::ADDR_MTIMECMP_H, 32'hFFFF_FFFF);
        confirm_level("timer_int", timer_int, 1'b0);
    endtask

    task automatic credit_ordering();
        timer_regs_pkg::timer_ctrl_word_u ctrl;
        timer_bus_pkg::timer_rsp_t        expected [5];
        timer_bus_pkg::timer_rsp_t        got;
        int                               pulses_before;
        int                               burst_start;
        if (host_credits != timer_bus_pkg::CREDIT_DEPTH) begin
            stop_on_failure("host does not hold every credit before the burst");
        end
        ctrl.raw           = '0;
        ctrl.ctrl.prescale = 8'($urandom_range(255));
        expected[0] = rsp_of(timer_bus_pkg::OK, 32'h0);
        expected[1] = rsp_of(timer_bus_pkg::OK, ctrl.raw);
        expected[2] = rsp_of(timer_bus_pkg::OK, 32'hFFFF_FFFF);
        expected[3] = rsp_of(timer_bus_pkg::BAD_ADDR, 32'h0);
        expected[4] = rsp_of(timer_bus_pkg::OK, 32'hFFFF_FFFF);
        pulses_before = credit_pulses;
        burst_start   = cycle_count;
        send_request(1'b1, timer_regs_pkg::ADDR_CTRL, ctrl.raw);
        send_request(1'b0, timer_regs_pkg::ADDR_CTRL, 32'h0);
        send_request(1'b0, timer_regs_pkg::ADDR_MTIMECMP_L, 32'h0);
        send_request(1'b0, 8'h2C, 32'h0);
        if (cycle_count - burst_start != 4) begin
            stop_on_failure("the four requests did not go out on back-to-back cycles");
        end
        send_request(1'b0, timer_regs_pkg::ADDR_MTIMECMP_H, 32'h0);
        for (int idx = 0; idx < 4; idx++) begin
            wait_response(got);
            compare_rsp("rsp", got, expected[idx]);
        end
        verify_count("credit_return pulses", 64'(credit_pulses - pulses_before), 64'd4, 64'd4);
        wait_response(got);
        compare_rsp("rsp", got, expected[4]);
        repeat (5) @(negedge CLK);
        verify_count("credit_return pulses", 64'(credit_pulses - pulses_before), 64'd5, 64'd5);
        if (rsp_queue.size() != 0) begin
            stop_on_failure("an extra response showed up after the burst");
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        stop_on_failure("watchdog expired before the tests finished");
    end

    initial begin
        CLK           = 1'b0;
        RST_N         = 1'b0;
        req_valid     = 1'b0;
        req           = '0;
        cycle_count   = 0;
        host_credits  = timer_bus_pkg::CREDIT_DEPTH;
        credit_pulses = 0;
        void'($urandom(41));
        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        RST_N = 1'b1;
        reset_values();
        disabled_and_read_only();
        prescaled_counting();
        compare_interrupt();
        credit_ordering();
        $display("Verification passed");
        $finish;
    end

endmodule

/* source/timer_subsystem.sv */
`timescale 1ns/1ps

module timer_subsystem (
    input  logic                      CLK,
    input  logic                      RST_N,
    input  logic                      req_valid,
    input  timer_bus_pkg::timer_req_t req,
    output logic                      rsp_valid,
    output timer_bus_pkg::timer_rsp_t rsp,
    output logic                      credit_return,
    output logic                      timer_int,
    output logic                      timer_pulse
);

    logic                       cmd_valid;
    timer_regs_pkg::timer_cmd_t cmd;
    logic                       fifo_valid;
    timer_regs_pkg::timer_cmd_t fifo_cmd;
    logic                       fifo_pop;

    // credit_return is fed back so the ingress count tracks the host
    timer_req_ingress timer_req_ingress_i (
        .CLK           (CLK),
        .RST_N         (RST_N),
        .req_valid     (req_valid),
        .req           (req),
        .credit_return (credit_return),
        .cmd_valid     (cmd_valid),
        .cmd           (cmd)
    );

    timer_req_fifo timer_req_fifo_i (
        .CLK        (CLK),
        .RST_N      (RST_N),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .fifo_pop   (fifo_pop),
        .fifo_valid (fifo_valid),
        .fifo_cmd   (fifo_cmd)
    );

    machine_timer machine_timer_i (
        .CLK           (CLK),
        .RST_N         (RST_N),
        .fifo_valid    (fifo_valid),
        .fifo_cmd      (fifo_cmd),
        .fifo_pop      (fifo_pop),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .credit_return (credit_return),
        .timer_int     (timer_int),
        .timer_pulse   (timer_pulse)
    );

endmodule

/* source/machine_timer.sv */
`timescale 1ns/1ps

module machine_timer (
    input  logic                       CLK,
    input  logic                       RST_N,
    input  logic                       fifo_valid,
    input  timer_regs_pkg::timer_cmd_t fifo_cmd,
    output logic                       fifo_pop,
    output logic                       rsp_valid,
    output timer_bus_pkg::timer_rsp_t  rsp,
    output logic                       credit_return,
    output logic                       timer_int,
    output logic                       timer_pulse
);

    timer_regs_pkg::timer_ctrl_word_u ctrl;
    timer_regs_pkg::timer_ctrl_word_u ctrl_wdata;
    logic [63:0]                      mtime;
    logic [63:0]                      mtimecmp;
    logic [7:0]                       presc_cnt;
    logic                             tick;
    logic                             ctrl_wr;
    logic                             cmp_l_wr;
    logic                             cmp_h_wr;
    timer_bus_pkg::timer_rsp_t        rsp_next;

    // one command per cycle so the head is never held back
    assign fifo_pop = fifo_valid;

    // reserved bits are dropped on the way in so they read back as zero
    always_comb begin
        ctrl_wdata               = fifo_cmd.data;
        ctrl_wdata.ctrl.reserved = '0;
    end

    // execute the head command and build its response
    always_comb begin
        ctrl_wr         = 1'b0;
        cmp_l_wr        = 1'b0;
        cmp_h_wr        = 1'b0;
        rsp_next.status = timer_bus_pkg::OK;
        rsp_next.data   = '0;
        case (fifo_cmd.sel)
            timer_regs_pkg::REG_CTRL: begin
                if (fifo_cmd.write) ctrl_wr = fifo_pop;
                else rsp_next.data = ctrl.raw;
            end
            timer_regs_pkg::REG_MTIME_L: begin
                if (fifo_cmd.write) rsp_next.status = timer_bus_pkg::READ_ONLY;
                else rsp_next.data = mtime[31:0];
            end
            timer_regs_pkg::REG_MTIME_H: begin
                if (fifo_cmd.write) rsp_next.status = timer_bus_pkg::READ_ONLY;
                else rsp_next.data = mtime[63:32];
            end
            timer_regs_pkg::REG_CMP_L: begin
                if (fifo_cmd.write) cmp_l_wr = fifo_pop;
                else rsp_next.data = mtimecmp[31:0];
            end
            timer_regs_pkg::REG_CMP_H: begin
                if (fifo_cmd.write) cmp_h_wr = fifo_pop;
                else rsp_next.data = mtimecmp[63:32];
            end
            default: begin
                rsp_next.status = timer_bus_pkg::BAD_ADDR;
            end
        endcase
    end

    always_ff @(posedge CLK) begin
        if (!RST_N) begin
            ctrl.raw <= timer_regs_pkg::CTRL_RESET;
        end else if (ctrl_wr) begin
            ctrl <= ctrl_wdata;
        end
    end

    always_ff @(posedge CLK) begin
        if (!RST_N) begin
            mtimecmp <= timer_regs_pkg::MTIMECMP_RESET;
        end else begin
            if (cmp_l_wr) mtimecmp[31:0]  <= fifo_cmd.data.raw;
            if (cmp_h_wr) mtimecmp[63:32] <= fifo_cmd.data.raw;
        end
    end

    // mtime steps on the cycle the prescaler reaches its limit
    assign tick = ctrl.ctrl.enable && (presc_cnt == ctrl.ctrl.prescale);

    always_ff @(posedge CLK) begin
        if (!RST_N) begin
            presc_cnt <= '0;
        end else if (ctrl_wr || tick || !ctrl.ctrl.enable) begin
            presc_cnt <= '0;    // a control write starts a fresh period
        end else begin
            presc_cnt <= presc_cnt + 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (!RST_N) begin
            mtime <= timer_regs_pkg::MTIME_RESET;
        end else if (tick) begin
            mtime <= mtime + 64'd1;
        end
    end

    assign timer_int   = (mtime >= mtimecmp);
    assign timer_pulse = (mtime == mtimecmp);   // one cycle wide when counting every cycle

    always_ff @(posedge CLK) begin
        if (!RST_N) begin
            rsp_valid     <= 1'b0;
            credit_return <= 1'b0;
        end else begin
            rsp_valid     <= fifo_pop;
            credit_return <= fifo_pop;  // the freed FIFO slot goes back to the host
        end
    end

    always_ff @(posedge CLK) begin
        if (fifo_pop) begin
            rsp <= rsp_next;
        end
    end

    // a new prescale value restarts the period so the count never runs past the limit
    a_presc_in_range: assert property (
        @(posedge CLK) disable iff (!RST_N)
        ctrl.ctrl.enable |-> presc_cnt <= ctrl.ctrl.prescale
    );

endmodule

/* source/timer_req_fifo.sv */
`timescale 1ns/1ps

module timer_req_fifo (
    input  logic                       CLK,
    input  logic                       RST_N,
    input  logic                       cmd_valid,
    input  timer_regs_pkg::timer_cmd_t cmd,
    input  logic                       fifo_pop,
    output logic                       fifo_valid,
    output timer_regs_pkg::timer_cmd_t fifo_cmd
);

    timer_regs_pkg::timer_cmd_t mem [timer_bus_pkg::CREDIT_DEPTH];

    logic [timer_bus_pkg::PTR_W-1:0]        wr_ptr;
    logic [timer_bus_pkg::PTR_W-1:0]        rd_ptr;
    logic [timer_bus_pkg::CREDIT_CNT_W-1:0] count;
    logic                                   full;

    assign full       = (count == timer_bus_pkg::CREDIT_MAX);
    assign fifo_valid = (count != '0);
    assign fifo_cmd   = mem[rd_ptr];   // head entry is always visible

    always_ff @(posedge CLK) begin
        if (cmd_valid) begin
            mem[wr_ptr] <= cmd;
        end
    end

    always_ff @(posedge CLK) begin
        if (!RST_N) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (cmd_valid) begin
                wr_ptr <= (wr_ptr == timer_bus_pkg::PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (fifo_pop) begin
                rd_ptr <= (rd_ptr == timer_bus_pkg::PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            // push and pop together leave the occupancy alone
            case ({cmd_valid, fifo_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // credits should make overflow impossible
    a_no_push_full: assert property (
        @(posedge CLK) disable iff (!RST_N)
        cmd_valid |-> !full
    );

    a_no_pop_empty: assert property (
        @(posedge CLK) disable iff (!RST_N)
        fifo_pop |-> fifo_valid
    );

endmodule

/* source/timer_req_ingress.sv */
`timescale 1ns/1ps

module timer_req_ingress (
    input  logic                      CLK,
    input  logic                      RST_N,
    input  logic                      req_valid,
    input  timer_bus_pkg::timer_req_t req,
    input  logic                      credit_return,
    output logic                      cmd_valid,
    output timer_regs_pkg::timer_cmd_t cmd
);

    // credits the host still holds, mirrors the host side count
    logic [timer_bus_pkg::CREDIT_CNT_W-1:0] credits;
    timer_regs_pkg::timer_reg_e             sel;

    // address decode, anything off the map becomes REG_NONE
    always_comb begin
        case (req.addr)
            timer_regs_pkg::ADDR_CTRL:       sel = timer_regs_pkg::REG_CTRL;
            timer_regs_pkg::ADDR_MTIME_L:    sel = timer_regs_pkg::REG_MTIME_L;
            timer_regs_pkg::ADDR_MTIME_H:    sel = timer_regs_pkg::REG_MTIME_H;
            timer_regs_pkg::ADDR_MTIMECMP_L: sel = timer_regs_pkg::REG_CMP_L;
            timer_regs_pkg::ADDR_MTIMECMP_H: sel = timer_regs_pkg::REG_CMP_H;
            default:                         sel = timer_regs_pkg::REG_NONE;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (!RST_N) begin
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= req_valid;     // one beat in, one command out a cycle later
        end
    end

    always_ff @(posedge CLK) begin
        if (req_valid) begin
            cmd.write    <= req.write;
            cmd.sel      <= sel;
            cmd.data.raw <= req.data;
        end
    end

    always_ff @(posedge CLK) begin
        if (!RST_N) begin
            credits <= timer_bus_pkg::CREDIT_MAX;
        end else begin
            case ({req_valid, credit_return})
                2'b10:   credits <= credits - 1'b1;  // host spent one
                2'b01:   credits <= credits + 1'b1;  // timer handed one back
                default: credits <= credits;         // both or neither cancel out
            endcase
        end
    end

    // the host may only send while it holds a credit
    a_beat_with_credit: assert property (
        @(posedge CLK) disable iff (!RST_N)
        req_valid |-> credits != '0
    );

    // more returns than beats means the timer answered something twice
    a_credit_bound: assert property (
        @(posedge CLK) disable iff (!RST_N)
        credits <= timer_bus_pkg::CREDIT_MAX
    );

endmodule

/* source/timer_regs_pkg.sv */
package timer_regs_pkg;

    // byte addresses of the register map
    localparam logic [7:0] ADDR_CTRL       = 8'h00;
    localparam logic [7:0] ADDR_MTIME_L    = 8'h04;
    localparam logic [7:0] ADDR_MTIME_H    = 8'h08;
    localparam logic [7:0] ADDR_MTIMECMP_L = 8'h0C;
    localparam logic [7:0] ADDR_MTIMECMP_H = 8'h10;

    // register select after address decode
    typedef enum logic [2:0] {
        REG_CTRL    = 3'd0,
        REG_MTIME_L = 3'd1,
        REG_MTIME_H = 3'd2,
        REG_CMP_L   = 3'd3,
        REG_CMP_H   = 3'd4,
        REG_NONE    = 3'd5
    } timer_reg_e;

    // control register fields
    typedef struct packed {
        logic [22:0] reserved;  // reads back as zero
        logic [7:0]  prescale;  // mtime advances every prescale + 1 cycles
        logic        enable;
    } timer_ctrl_t;

    // the bus carries the control word raw while the timer looks at its fields
    typedef union packed {
        logic [31:0] raw;
        timer_ctrl_t ctrl;
    } timer_ctrl_word_u;

    localparam logic [31:0] CTRL_RESET     = 32'h0;     // counter disabled
    localparam logic [63:0] MTIME_RESET    = 64'h0;
    localparam logic [63:0] MTIMECMP_RESET = '1;        // no interrupt until written

    // decoded request as it sits in the FIFO
    typedef struct packed {
        logic             write;
        timer_reg_e       sel;
        timer_ctrl_word_u data;
    } timer_cmd_t;

endpackage

/* source/timer_bus_pkg.sv */
package timer_bus_pkg;

    // credits the host holds after reset and also the request FIFO depth
    localparam int CREDIT_DEPTH = 4;

    // credit counter has to hold the full value so it needs one extra code
    localparam int CREDIT_CNT_W = $clog2(CREDIT_DEPTH + 1);
    localparam logic [CREDIT_CNT_W-1:0] CREDIT_MAX = CREDIT_CNT_W'(CREDIT_DEPTH);

    // FIFO pointers index the CREDIT_DEPTH entries
    localparam int PTR_W = $clog2(CREDIT_DEPTH);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(CREDIT_DEPTH - 1);

    // one host request beat
    typedef struct packed {
        logic        write;
        logic [7:0]  addr;  // byte address into the register map
        logic [31:0] data;  // write data, ignored on reads
    } timer_req_t;

    typedef enum logic [1:0] {
        OK        = 2'd0,
        BAD_ADDR  = 2'd1,   // nothing mapped at the address
        READ_ONLY = 2'd2    // write aimed at mtime
    } timer_status_e;

    // one response per request, returned in request order
    typedef struct packed {
        timer_status_e status;
        logic [31:0]   data;    // read value or zero
    } timer_rsp_t;

endpackage
